// ==== include/rs_settings.svh ====
// Sizes for the reservation station; RS_ENTRIES must be a power of two and ROB wrap is not handled
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// Number of station entries
`define RS_ENTRIES 8

// Physical register tag width
`define RS_PREG_BITS 6

// Operand and result width
`define RS_DATA_BITS 32

// ROB index width where a lower index is older
`define RS_ROB_BITS 7

// ALU operation code width
`define RS_OP_BITS 4

`endif

// ==== src/rs_pkg.sv ====
// Shared vector types of the reservation station; widths come from rs_settings.svh
`include "rs_settings.svh"

package rs_pkg;

    // Physical register tag
    typedef logic [`RS_PREG_BITS-1:0] preg_t;

    // Operand or result value
    typedef logic [`RS_DATA_BITS-1:0] data_t;

    // Age tag where smaller is older
    typedef logic [`RS_ROB_BITS-1:0] rob_idx_t;

    // Opaque ALU operation
    typedef logic [`RS_OP_BITS-1:0] alu_op_t;

    // Entry index and per-entry flags
    typedef logic [$clog2(`RS_ENTRIES)-1:0] rs_idx_t;
    typedef logic [`RS_ENTRIES-1:0]         rs_mask_t;

    // Holds 0 up to RS_ENTRIES
    typedef logic [$clog2(`RS_ENTRIES+1)-1:0] rs_count_t;

endpackage

// ==== src/rs_sched_if.sv ====
// Entry state out to the allocator and selector and their picks back; purely combinational
`timescale 1ns/1ps
`include "rs_settings.svh"

interface rs_sched_if;

    // State published by the entry file
    rs_pkg::rs_mask_t free_mask;             // Entry not valid
    rs_pkg::rs_mask_t ready_mask;            // Valid, not issued, both sources ready
    rs_pkg::rob_idx_t entry_age [`RS_ENTRIES];

    // Allocator pick
    logic             alloc_valid;
    rs_pkg::rs_idx_t  alloc_idx;

    // Selector pick
    logic             sel_valid;
    rs_pkg::rs_idx_t  sel_idx;

    modport store (
        output free_mask, ready_mask, entry_age,
        input  alloc_valid, alloc_idx, sel_valid, sel_idx
    );

    modport alloc (
        input  free_mask,
        output alloc_valid, alloc_idx
    );

    modport select (
        input  ready_mask, entry_age,
        output sel_valid, sel_idx
    );

endinterface

// ==== src/rs_alloc.sv ====
// Lowest free entry for the next dispatch; alloc_valid is low when the station is full
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_alloc (
    rs_sched_if.alloc sched
);

    // Priority encoder scanning from the top so the lowest free index wins
    always_comb begin
        sched.alloc_valid = 1'b0;
        sched.alloc_idx   = '0;
        for (int i = `RS_ENTRIES - 1; i >= 0; i--) begin
            if (sched.free_mask[i]) begin
                sched.alloc_valid = 1'b1;
                sched.alloc_idx   = rs_pkg::rs_idx_t'(i);
            end
        end
    end

endmodule

// ==== src/rs_select.sv ====
// Oldest ready entry by ROB index; ROB wrap is not handled, equal ages go to the lower entry
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_select (
    rs_sched_if.select sched
);

    // Linear scan keeping the smallest age seen so far
    always_comb begin
        rs_pkg::rob_idx_t best_age;

        best_age        = '1;
        sched.sel_valid = 1'b0;
        sched.sel_idx   = '0;

        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (sched.ready_mask[i]) begin
                // Strict compare keeps the lower index on a tie
                if (!sched.sel_valid || sched.entry_age[i] < best_age) begin
                    sched.sel_valid = 1'b1;
                    sched.sel_idx   = rs_pkg::rs_idx_t'(i);
                    best_age        = sched.entry_age[i];
                end
            end
        end
    end

endmodule

// ==== src/rs_entry_file.sv ====
// One dispatch, CDB and issue port; the issue payload is undefined while issue_valid is low
`timescale 1ns/1ps
`include "rs_settings.svh"

module rs_entry_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,

    input  logic               dispatch_valid,
    input  rs_pkg::preg_t      dispatch_prs1,
    input  rs_pkg::preg_t      dispatch_prs2,
    input  rs_pkg::preg_t      dispatch_prd,
    input  rs_pkg::data_t      dispatch_src1_value,
    input  rs_pkg::data_t      dispatch_src2_value,
    input  logic               dispatch_src1_ready,
    input  logic               dispatch_src2_ready,
    input  rs_pkg::alu_op_t    dispatch_op,
    input  rs_pkg::rob_idx_t   dispatch_rob_idx,

    input  logic               cdb_valid,
    input  rs_pkg::preg_t      cdb_tag,
    input  rs_pkg::data_t      cdb_data,

    input  logic               issue_ack,
    output logic               issue_valid,
    output rs_pkg::preg_t      issue_prd,
    output rs_pkg::data_t      issue_src1,
    output rs_pkg::data_t      issue_src2,
    output rs_pkg::alu_op_t    issue_op,
    output rs_pkg::rob_idx_t   issue_rob_idx,

    output rs_pkg::rs_count_t  free_count,
    output logic               full,
    output logic               empty,

    rs_sched_if.store          sched
);

    // Control state
    rs_pkg::rs_mask_t valid;
    rs_pkg::rs_mask_t issued;                  // Sent to a unit, waiting for its CDB result

    // Payload
    rs_pkg::preg_t    prs1     [`RS_ENTRIES];
    rs_pkg::preg_t    prs2     [`RS_ENTRIES];
    rs_pkg::preg_t    prd      [`RS_ENTRIES];
    rs_pkg::data_t    src1_val [`RS_ENTRIES];
    rs_pkg::data_t    src2_val [`RS_ENTRIES];
    rs_pkg::rs_mask_t src1_rdy;
    rs_pkg::rs_mask_t src2_rdy;
    rs_pkg::alu_op_t  op       [`RS_ENTRIES];
    rs_pkg::rob_idx_t rob_idx  [`RS_ENTRIES];

    logic dispatch_fire;
    logic issue_fire;

    assign dispatch_fire = dispatch_valid && sched.alloc_valid;  // Dropped when full
    assign issue_fire    = issue_valid && issue_ack;

    // Published state
    assign sched.free_mask  = ~valid;
    assign sched.ready_mask = valid & ~issued & src1_rdy & src2_rdy;
    assign sched.entry_age  = rob_idx;

    // Issue port
    assign issue_valid   = sched.sel_valid;
    assign issue_prd     = prd[sched.sel_idx];
    assign issue_src1    = src1_val[sched.sel_idx];
    assign issue_src2    = src2_val[sched.sel_idx];
    assign issue_op      = op[sched.sel_idx];
    assign issue_rob_idx = rob_idx[sched.sel_idx];

    // Occupancy
    always_comb begin
        free_count = '0;
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            free_count = free_count + rs_pkg::rs_count_t'(sched.free_mask[i]);
        end
    end

    assign full  = (free_count == '0);
    assign empty = (free_count == rs_pkg::rs_count_t'(`RS_ENTRIES));

    // Issue marking, release, then dispatch; the last write to an entry wins
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid  <= '0;
            issued <= '0;
        end else begin
            if (issue_fire) issued[sched.sel_idx] <= 1'b1;
            for (int i = 0; i < `RS_ENTRIES; i++) begin
                if (cdb_valid && valid[i] && issued[i] && prd[i] == cdb_tag) begin
                    valid[i]  <= 1'b0;             // Result is out so the slot is freed
                    issued[i] <= 1'b0;
                end
            end
            if (dispatch_fire) begin
                valid[sched.alloc_idx]  <= 1'b1;
                issued[sched.alloc_idx] <= 1'b0;
            end
        end
    end

    // Wake-up of waiting sources, then dispatch write
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            if (cdb_valid && valid[i] && !issued[i]) begin
                if (!src1_rdy[i] && prs1[i] == cdb_tag) begin
                    src1_val[i] <= cdb_data;
                    src1_rdy[i] <= 1'b1;
                end
                if (!src2_rdy[i] && prs2[i] == cdb_tag) begin
                    src2_val[i] <= cdb_data;
                    src2_rdy[i] <= 1'b1;
                end
            end
        end
        if (dispatch_fire) begin
            prs1[sched.alloc_idx]     <= dispatch_prs1;
            prs2[sched.alloc_idx]     <= dispatch_prs2;
            prd[sched.alloc_idx]      <= dispatch_prd;
            op[sched.alloc_idx]       <= dispatch_op;
            rob_idx[sched.alloc_idx]  <= dispatch_rob_idx;
            src1_val[sched.alloc_idx] <= dispatch_src1_value;
            src2_val[sched.alloc_idx] <= dispatch_src2_value;
            src1_rdy[sched.alloc_idx] <= dispatch_src1_ready;
            src2_rdy[sched.alloc_idx] <= dispatch_src2_ready;
            // Result on the CDB this very cycle is stored already woken
            if (cdb_valid && !dispatch_src1_ready && dispatch_prs1 == cdb_tag) begin
                src1_val[sched.alloc_idx] <= cdb_data;
                src1_rdy[sched.alloc_idx] <= 1'b1;
            end
            if (cdb_valid && !dispatch_src2_ready && dispatch_prs2 == cdb_tag) begin
                src2_val[sched.alloc_idx] <= cdb_data;
                src2_rdy[sched.alloc_idx] <= 1'b1;
            end
        end
    end

    // Rename stage must hold off while the station is full
    assert property (@(posedge clk) disable iff (rst) !(dispatch_valid && full))
        else $error("dispatch while full, instruction lost");

    // Functional unit only acknowledges an offered instruction
    assert property (@(posedge clk) disable iff (rst) !(issue_ack && !issue_valid))
        else $error("issue_ack without issue_valid");

endmodule

// ==== src/rs_top.sv ====
// Reservation station top with 8 entries, one dispatch, one issue and one CDB slot
`timescale 1ns/1ps

module rs_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,

    input  logic               dispatch_valid,
    input  rs_pkg::preg_t      dispatch_prs1,
    input  rs_pkg::preg_t      dispatch_prs2,
    input  rs_pkg::preg_t      dispatch_prd,
    input  rs_pkg::data_t      dispatch_src1_value,
    input  rs_pkg::data_t      dispatch_src2_value,
    input  logic               dispatch_src1_ready,
    input  logic               dispatch_src2_ready,
    input  rs_pkg::alu_op_t    dispatch_op,
    input  rs_pkg::rob_idx_t   dispatch_rob_idx,

    input  logic               cdb_valid,
    input  rs_pkg::preg_t      cdb_tag,
    input  rs_pkg::data_t      cdb_data,

    input  logic               issue_ack,
    output logic               issue_valid,
    output rs_pkg::preg_t      issue_prd,
    output rs_pkg::data_t      issue_src1,
    output rs_pkg::data_t      issue_src2,
    output rs_pkg::alu_op_t    issue_op,
    output rs_pkg::rob_idx_t   issue_rob_idx,

    output rs_pkg::rs_count_t  free_count,
    output logic               full,
    output logic               empty
);

    rs_sched_if sched ();

    // Allocator and selector look at the same state side by side
    rs_alloc u_alloc (.sched(sched));

    rs_select u_select (.sched(sched));

    rs_entry_file u_entries (
        .clk                 (clk),
        .rst                 (rst),
        .flush               (flush),
        .dispatch_valid      (dispatch_valid),
        .dispatch_prs1       (dispatch_prs1),
        .dispatch_prs2       (dispatch_prs2),
        .dispatch_prd        (dispatch_prd),
        .dispatch_src1_value (dispatch_src1_value),
        .dispatch_src2_value (dispatch_src2_value),
        .dispatch_src1_ready (dispatch_src1_ready),
        .dispatch_src2_ready (dispatch_src2_ready),
        .dispatch_op         (dispatch_op),
        .dispatch_rob_idx    (dispatch_rob_idx),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .cdb_data            (cdb_data),
        .issue_ack           (issue_ack),
        .issue_valid         (issue_valid),
        .issue_prd           (issue_prd),
        .issue_src1          (issue_src1),
        .issue_src2          (issue_src2),
        .issue_op            (issue_op),
        .issue_rob_idx       (issue_rob_idx),
        .free_count          (free_count),
        .full                (full),
        .empty               (empty),
        .sched               (sched)
    );

endmodule

// ==== tb/tb_rs_top.sv ====
// Directed tests of the reservation station; payload ordering assumes ROB indices do not wrap
`timescale 1ns/1ps
`include "rs_settings.svh"

module tb_rs_top;

    localparam int MAX_CYCLES = 600;            // Generous bound over the directed tests

    logic               clk;
    logic               rst;
    logic               flush;
    logic               dispatch_valid;
    rs_pkg::preg_t      dispatch_prs1;
    rs_pkg::preg_t      dispatch_prs2;
    rs_pkg::preg_t      dispatch_prd;
    rs_pkg::data_t      dispatch_src1_value;
    rs_pkg::data_t      dispatch_src2_value;
    logic               dispatch_src1_ready;
    logic               dispatch_src2_ready;
    rs_pkg::alu_op_t    dispatch_op;
    rs_pkg::rob_idx_t   dispatch_rob_idx;
    logic               cdb_valid;
    rs_pkg::preg_t      cdb_tag;
    rs_pkg::data_t      cdb_data;
    logic               issue_ack;
    logic               issue_valid;
    rs_pkg::preg_t      issue_prd;
    rs_pkg::data_t      issue_src1;
    rs_pkg::data_t      issue_src2;
    rs_pkg::alu_op_t    issue_op;
    rs_pkg::rob_idx_t   issue_rob_idx;
    rs_pkg::rs_count_t  free_count;
    logic               full;
    logic               empty;

    logic [31:0] rng_state;
    int          cycles;

    rs_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $fatal(1);
        end
    end

    function logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Move to the drive point of the next cycle and drop all strobes
    task automatic tick();
        @(posedge clk);
        #5;
        dispatch_valid = 1'b0;
        cdb_valid      = 1'b0;
        issue_ack      = 1'b0;
        flush          = 1'b0;
    endtask

    task automatic dispatch_instr(input rs_pkg::preg_t prs1, input rs_pkg::preg_t prs2,
                                  input rs_pkg::preg_t prd, input rs_pkg::data_t v1,
                                  input rs_pkg::data_t v2, input logic r1, input logic r2,
                                  input rs_pkg::alu_op_t op, input rs_pkg::rob_idx_t rob);
        dispatch_valid      = 1'b1;
        dispatch_prs1       = prs1;
        dispatch_prs2       = prs2;
        dispatch_prd        = prd;
        dispatch_src1_value = v1;
        dispatch_src2_value = v2;
        dispatch_src1_ready = r1;
        dispatch_src2_ready = r2;
        dispatch_op         = op;
        dispatch_rob_idx    = rob;
    endtask

    task automatic broadcast_cdb(input rs_pkg::preg_t tag, input rs_pkg::data_t data);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_data  = data;
    endtask

    task automatic reset_state();
        check(issue_valid, 0, "issue_valid after reset");
        check(empty, 1, "empty after reset");
        check(full, 0, "full after reset");
        check(free_count, `RS_ENTRIES, "free_count after reset");
    endtask

    task automatic ready_issue();
        rs_pkg::data_t v1;
        rs_pkg::data_t v2;

        v1 = next_random();
        v2 = next_random();
        dispatch_instr(6'd1, 6'd2, 6'd10, v1, v2, 1'b1, 1'b1, 4'h3, 7'd12);
        tick();
        // Ack held low for two cycles keeps the same entry on offer
        repeat (2) begin
            check(issue_valid, 1, "ready dispatch offered");
            check(issue_prd, 10, "issue_prd");
            check(issue_src1, v1, "issue_src1");
            check(issue_src2, v2, "issue_src2");
            check(issue_op, 4'h3, "issue_op");
            check(issue_rob_idx, 12, "issue_rob_idx");
            tick();
        end
        issue_ack = 1'b1;
        tick();
        check(issue_valid, 0, "issue_valid after ack");
        check(free_count, 7, "issued entry still held");
        broadcast_cdb(6'd10, next_random());
        tick();
        check(free_count, 8, "free_count after release");
        check(empty, 1, "empty after release");
    endtask

    task automatic cdb_wakeup();
        rs_pkg::data_t v2;
        rs_pkg::data_t v3;
        rs_pkg::data_t d1;
        rs_pkg::data_t d2;

        v2 = next_random();
        v3 = next_random();
        d1 = next_random();
        d2 = next_random();
        dispatch_instr(6'd20, 6'd21, 6'd30, 32'h0, v2, 1'b0, 1'b1, 4'h5, 7'd1);
        tick();
        check(issue_valid, 0, "waiting source blocks issue");
        broadcast_cdb(6'd22, next_random());          // Unrelated tag
        tick();
        check(issue_valid, 0, "non-matching tag woke an entry");
        broadcast_cdb(6'd20, d1);
        tick();
        check(issue_valid, 1, "wake-up by CDB");
        check(issue_src1, d1, "woken src1 value");
        check(issue_src2, v2, "src2 kept");
        check(issue_prd, 30, "woken issue_prd");
        issue_ack = 1'b1;
        tick();
        // Consumer of prd 30 arrives in the very cycle that result is broadcast
        dispatch_instr(6'd24, 6'd30, 6'd31, v3, 32'h0, 1'b1, 1'b0, 4'h6, 7'd2);
        broadcast_cdb(6'd30, d2);
        tick();
        check(issue_valid, 1, "same-cycle wake-up");
        check(issue_src1, v3, "same-cycle src1");
        check(issue_src2, d2, "same-cycle src2 from CDB");
        check(issue_prd, 31, "same-cycle issue_prd");
        check(free_count, 7, "release and dispatch together");
        issue_ack = 1'b1;
        tick();
        broadcast_cdb(6'd31, next_random());
        tick();
        check(empty, 1, "empty after wake-up test");
    endtask

    task automatic age_order();
        rs_pkg::rob_idx_t robs  [4];
        rs_pkg::rob_idx_t order [4];

        robs  = '{7'd9, 7'd3, 7'd7, 7'd5};
        order = '{7'd3, 7'd5, 7'd7, 7'd9};
        for (int i = 0; i < 4; i++) begin
            dispatch_instr(6'd0, 6'd0, rs_pkg::preg_t'(40 + i), next_random(), next_random(),
                           1'b1, 1'b1, 4'h1, robs[i]);
            tick();
        end
        for (int k = 0; k < 4; k++) begin
            check(issue_valid, 1, "ready entry offered in age test");
            check(issue_rob_idx, order[k], "oldest ROB index first");
            issue_ack = 1'b1;
            tick();
        end
        check(issue_valid, 0, "all aged entries issued");
        for (int i = 0; i < 4; i++) begin
            broadcast_cdb(rs_pkg::preg_t'(40 + i), next_random());
            tick();
        end
        check(empty, 1, "empty after age test");
    endtask

    task automatic fill_and_flush();
        for (int i = 0; i < `RS_ENTRIES; i++) begin
            dispatch_instr(rs_pkg::preg_t'(50 + i), 6'd0, rs_pkg::preg_t'(i), 32'h0,
                           next_random(), 1'b0, 1'b1, 4'h2, rs_pkg::rob_idx_t'(20 + i));
            tick();
        end
        check(full, 1, "full after eight dispatches");
        check(free_count, 0, "free_count when full");
        check(issue_valid, 0, "nothing ready when full");
        flush = 1'b1;
        // Would wake entry 0 if the flush left it in place
        broadcast_cdb(6'd50, next_random());
        tick();
        check(empty, 1, "empty after flush");
        check(full, 0, "full after flush");
        check(free_count, `RS_ENTRIES, "free_count after flush");
        check(issue_valid, 0, "issue_valid after flush");
    endtask

    initial begin
        rng_state           = 32'h4ac2_a90c;
        cycles              = 0;
        rst                 = 1'b1;
        flush               = 1'b0;
        dispatch_valid      = 1'b0;
        dispatch_prs1       = '0;
        dispatch_prs2       = '0;
        dispatch_prd        = '0;
        dispatch_src1_value = '0;
        dispatch_src2_value = '0;
        dispatch_src1_ready = 1'b0;
        dispatch_src2_ready = 1'b0;
        dispatch_op         = '0;
        dispatch_rob_idx    = '0;
        cdb_valid           = 1'b0;
        cdb_tag             = '0;
        cdb_data            = '0;
        issue_ack           = 1'b0;

        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;

        reset_state();
        ready_issue();
        cdb_wakeup();
        age_order();
        fill_and_flush();

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== rs_sched.f ====
+incdir+include
src/rs_pkg.sv
src/rs_sched_if.sv
src/rs_alloc.sv
src/rs_select.sv
src/rs_entry_file.sv
src/rs_top.sv
tb/tb_rs_top.sv
